//--- source/rv32i_pkg.sv
// RV32I base opcodes and fields only. Compressed and extension encodings are not covered
package rv32i_pkg;

    // Architectural register file
    localparam int areg_w     = 5;
    localparam int areg_count = 2 ** areg_w;

    // Low bit of each register field in the instruction word
    localparam int rd_lsb  = 7;
    localparam int rs1_lsb = 15;
    localparam int rs2_lsb = 20;

    // Major opcodes, bits [6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

endpackage

//--- source/rename_pkg.sv
// All depths here must be powers of two since the pointers wrap on their own width
package rename_pkg;

    // Physical register file
    localparam int preg_count = 64;
    localparam int preg_w     = 6;

    // Free list covers the upper half of the physical registers
    localparam int fl_depth = preg_count / 2;
    localparam int fl_ptr_w = $clog2(fl_depth);
    localparam int fl_cnt_w = $clog2(fl_depth + 1);
    localparam logic [preg_w-1:0] fl_first = preg_w'(preg_count - fl_depth);

    // Reorder buffer
    localparam int rob_depth = 8;
    localparam int rob_id_w  = 3;
    localparam int rob_cnt_w = $clog2(rob_depth + 1);

    // Instruction queue, one fetch credit per entry
    localparam int iq_depth = 4;
    localparam int iq_ptr_w = $clog2(iq_depth);
    localparam int iq_cnt_w = $clog2(iq_depth + 1);

    // Reservation station slots granted at reset
    localparam int rs_credits = 4;
    localparam int rs_cred_w  = $clog2(rs_credits + 1);

endpackage

//--- source/inst_queue.sv
// Has no overflow check and relies on the fetcher never pushing without a credit
`timescale 1ns/1ps

module inst_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    input  logic [31:0] in_pc,
    input  logic        q_pop,
    output logic        q_empty,
    output logic [31:0] q_inst,
    output logic [31:0] q_pc,
    output logic        in_credit
);

    // Entry storage
    logic [31:0] inst_mem [rename_pkg::iq_depth];
    logic [31:0] pc_mem [rename_pkg::iq_depth];

    logic [rename_pkg::iq_ptr_w-1:0] rd_ptr;
    logic [rename_pkg::iq_ptr_w-1:0] wr_ptr;
    logic [rename_pkg::iq_cnt_w-1:0] count;
    logic do_pop;

    // Pop only a real entry
    assign do_pop  = q_pop && !q_empty;
    assign q_empty = (count == '0);

    // Head entry straight out of storage
    assign q_inst = inst_mem[rd_ptr];
    assign q_pc   = pc_mem[rd_ptr];

    // Payload write
    always_ff @(posedge clk) begin
        if (in_valid) begin
            inst_mem[wr_ptr] <= in_inst;
            pc_mem[wr_ptr]   <= in_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to fetch per freed slot
            in_credit <= do_pop;
        end
    end

endmodule

//--- source/free_list.sv
// Retirement must never return more pregs than were taken, since a full list is not checked
`timescale 1ns/1ps

module free_list (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fl_pop,
    input  logic                          retire_valid,
    input  logic [rename_pkg::preg_w-1:0] retire_preg,
    output logic                          fl_empty,
    output logic [rename_pkg::preg_w-1:0] fl_preg
);

    logic [rename_pkg::preg_w-1:0] fl_mem [rename_pkg::fl_depth];
    logic [rename_pkg::fl_ptr_w-1:0] head;
    logic [rename_pkg::fl_ptr_w-1:0] tail;
    logic [rename_pkg::fl_cnt_w-1:0] count;
    logic do_pop;
    logic do_push;

    assign fl_empty = (count == '0);
    assign fl_preg  = fl_mem[head];
    assign do_pop   = fl_pop && !fl_empty;
    // Preg 0 backs x0 and never enters the list
    assign do_push  = retire_valid && (retire_preg != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts full with the upper pregs in ascending order
            for (int i = 0; i < rename_pkg::fl_depth; i++) begin
                fl_mem[i] <= rename_pkg::fl_first + i[rename_pkg::preg_w-1:0];
            end
            head  <= '0;
            tail  <= '0;
            count <= rename_pkg::fl_depth[rename_pkg::fl_cnt_w-1:0];
        end else begin
            if (do_pop) begin
                head <= head + 1'b1;
            end
            if (do_push) begin
                fl_mem[tail] <= retire_preg;
                tail         <= tail + 1'b1;
            end
            // Pop and return in one cycle leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/rename_table.sv
// Lookups see a writeback of the same cycle, and a rename in that cycle shows only after the edge
`timescale 1ns/1ps

module rename_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rv32i_pkg::areg_w-1:0]  rs1_areg,
    input  logic [rv32i_pkg::areg_w-1:0]  rs2_areg,
    input  logic                          ren_valid,
    input  logic [rv32i_pkg::areg_w-1:0]  ren_areg,
    input  logic [rename_pkg::preg_w-1:0] ren_preg,
    input  logic                          wb_valid,
    input  logic [rename_pkg::preg_w-1:0] wb_preg,
    output logic [rename_pkg::preg_w-1:0] rs1_preg,
    output logic                          rs1_busy,
    output logic [rename_pkg::preg_w-1:0] rs2_preg,
    output logic                          rs2_busy
);

    // Current mapping and pending-result flag per architectural register
    logic [rename_pkg::preg_w-1:0] map [rv32i_pkg::areg_count];
    logic [rv32i_pkg::areg_count-1:0] busy;

    // Entry 0 is never written so x0 reads preg 0 and not busy
    assign rs1_preg = map[rs1_areg];
    assign rs2_preg = map[rs2_areg];

    // Same-cycle writeback counts as done, or the wakeup would be missed
    assign rs1_busy = busy[rs1_areg] && !(wb_valid && (wb_preg == map[rs1_areg]));
    assign rs2_busy = busy[rs2_areg] && !(wb_valid && (wb_preg == map[rs2_areg]));

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, nothing in flight
            for (int i = 0; i < rv32i_pkg::areg_count; i++) begin
                map[i] <= i[rename_pkg::preg_w-1:0];
            end
            busy <= '0;
        end else begin
            for (int i = 1; i < rv32i_pkg::areg_count; i++) begin
                // Writeback clears every entry naming that preg
                if (wb_valid && (map[i] == wb_preg)) begin
                    busy[i] <= 1'b0;
                end
                // Later assignment so a rename overrides the clear
                if (ren_valid && (ren_areg == i[rv32i_pkg::areg_w-1:0])) begin
                    map[i]  <= ren_preg;
                    busy[i] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/dispatcher.sv
// Single issue, and retire_valid must only pulse for a dispatched instruction
`timescale 1ns/1ps

module dispatcher (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            q_empty,
    input  logic [31:0]                     q_inst,
    input  logic [31:0]                     q_pc,
    input  logic                            fl_empty,
    input  logic [rename_pkg::preg_w-1:0]   fl_preg,
    input  logic [rename_pkg::preg_w-1:0]   rs1_preg,
    input  logic                            rs1_busy,
    input  logic [rename_pkg::preg_w-1:0]   rs2_preg,
    input  logic                            rs2_busy,
    input  logic                            credit_avail,
    input  logic                            retire_valid,
    output logic                            q_pop,
    output logic                            fl_pop,
    output logic [rv32i_pkg::areg_w-1:0]    rs1_areg,
    output logic [rv32i_pkg::areg_w-1:0]    rs2_areg,
    output logic                            ren_valid,
    output logic [rv32i_pkg::areg_w-1:0]    ren_areg,
    output logic [rename_pkg::preg_w-1:0]   ren_preg,
    output logic                            disp_valid,
    output logic [31:0]                     disp_inst,
    output logic [31:0]                     disp_pc,
    output logic [rename_pkg::rob_id_w-1:0] disp_rob_id,
    output logic [rename_pkg::preg_w-1:0]   disp_rs1_preg,
    output logic                            disp_rs1_ready,
    output logic [rename_pkg::preg_w-1:0]   disp_rs2_preg,
    output logic                            disp_rs2_ready,
    output logic [rename_pkg::preg_w-1:0]   disp_rd_preg
);

    logic [rename_pkg::rob_cnt_w-1:0] rob_count;
    logic [rename_pkg::rob_id_w-1:0]  rob_id;
    logic [rv32i_pkg::areg_w-1:0]     rd_field;
    logic use_rs1;
    logic use_rs2;
    logic use_rd;
    logic rd_renamed;
    logic rob_full;
    logic dispatch;

    // Operand use by opcode, unknown opcodes touch no registers
    always_comb begin
        case (q_inst[6:0])
            rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal:
                {use_rs1, use_rs2, use_rd} = 3'b001;
            rv32i_pkg::op_jalr, rv32i_pkg::op_load, rv32i_pkg::op_imm:
                {use_rs1, use_rs2, use_rd} = 3'b101;
            rv32i_pkg::op_branch, rv32i_pkg::op_store:
                {use_rs1, use_rs2, use_rd} = 3'b110;
            rv32i_pkg::op_reg:
                {use_rs1, use_rs2, use_rd} = 3'b111;
            default:
                {use_rs1, use_rs2, use_rd} = 3'b000;
        endcase
    end

    // Unused sources look up x0, which returns preg 0 and ready
    assign rs1_areg = use_rs1 ? q_inst[rv32i_pkg::rs1_lsb +: rv32i_pkg::areg_w] : '0;
    assign rs2_areg = use_rs2 ? q_inst[rv32i_pkg::rs2_lsb +: rv32i_pkg::areg_w] : '0;
    assign rd_field = q_inst[rv32i_pkg::rd_lsb +: rv32i_pkg::areg_w];

    // x0 destination takes no free preg
    assign rd_renamed = use_rd && (rd_field != '0);
    // Count of rob_depth sets the top bit
    assign rob_full   = rob_count[rename_pkg::rob_id_w];
    assign dispatch   = !q_empty && credit_avail && !rob_full && (!rd_renamed || !fl_empty);

    // Queue, free list and map all move in the dispatch cycle
    assign q_pop     = dispatch;
    assign fl_pop    = dispatch && rd_renamed;
    assign ren_valid = dispatch && rd_renamed;
    assign ren_areg  = rd_field;
    assign ren_preg  = fl_preg;

    // Entry toward the output register
    assign disp_valid     = dispatch;
    assign disp_inst      = q_inst;
    assign disp_pc        = q_pc;
    assign disp_rob_id    = rob_id;
    assign disp_rs1_preg  = rs1_preg;
    assign disp_rs1_ready = !rs1_busy;
    assign disp_rs2_preg  = rs2_preg;
    assign disp_rs2_ready = !rs2_busy;
    assign disp_rd_preg   = rd_renamed ? fl_preg : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            rob_count <= '0;
            rob_id    <= '0;
        end else begin
            case ({dispatch, retire_valid})
                2'b10:   rob_count <= rob_count + 1'b1;
                2'b01:   rob_count <= rob_count - 1'b1;
                default: rob_count <= rob_count;
            endcase
            // Id wraps on its own width
            if (dispatch) begin
                rob_id <= rob_id + 1'b1;
            end
        end
    end

endmodule

//--- source/dispatch_credit_out.sv
// Credit is spent when the entry is captured, one cycle before out_valid shows it
`timescale 1ns/1ps

module dispatch_credit_out (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            disp_valid,
    input  logic [31:0]                     disp_inst,
    input  logic [31:0]                     disp_pc,
    input  logic [rename_pkg::rob_id_w-1:0] disp_rob_id,
    input  logic [rename_pkg::preg_w-1:0]   disp_rs1_preg,
    input  logic                            disp_rs1_ready,
    input  logic [rename_pkg::preg_w-1:0]   disp_rs2_preg,
    input  logic                            disp_rs2_ready,
    input  logic [rename_pkg::preg_w-1:0]   disp_rd_preg,
    input  logic                            out_credit,
    output logic                            credit_avail,
    output logic                            out_valid,
    output logic [31:0]                     out_inst,
    output logic [31:0]                     out_pc,
    output logic [rename_pkg::rob_id_w-1:0] out_rob_id,
    output logic [rename_pkg::preg_w-1:0]   out_rs1_preg,
    output logic                            out_rs1_ready,
    output logic [rename_pkg::preg_w-1:0]   out_rs2_preg,
    output logic                            out_rs2_ready,
    output logic [rename_pkg::preg_w-1:0]   out_rd_preg
);

    // Free reservation station slots
    logic [rename_pkg::rs_cred_w-1:0] credits;

    assign credit_avail = (credits != '0);

    // Payload capture
    always_ff @(posedge clk) begin
        if (disp_valid) begin
            out_inst      <= disp_inst;
            out_pc        <= disp_pc;
            out_rob_id    <= disp_rob_id;
            out_rs1_preg  <= disp_rs1_preg;
            out_rs1_ready <= disp_rs1_ready;
            out_rs2_preg  <= disp_rs2_preg;
            out_rs2_ready <= disp_rs2_ready;
            out_rd_preg   <= disp_rd_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            credits   <= rename_pkg::rs_credits[rename_pkg::rs_cred_w-1:0];
        end else begin
            out_valid <= disp_valid;
            // Spend and return together cancel
            case ({disp_valid, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- source/rename_dispatch_top.sv
// Retire and writeback come from outside, as ROB and execution units are not part of this block
`timescale 1ns/1ps

module rename_dispatch_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic [31:0]                     in_inst,
    input  logic [31:0]                     in_pc,
    input  logic                            out_credit,
    input  logic                            wb_valid,
    input  logic [rename_pkg::preg_w-1:0]   wb_preg,
    input  logic                            retire_valid,
    input  logic [rename_pkg::preg_w-1:0]   retire_preg,
    output logic                            in_credit,
    output logic                            out_valid,
    output logic [31:0]                     out_inst,
    output logic [31:0]                     out_pc,
    output logic [rename_pkg::rob_id_w-1:0] out_rob_id,
    output logic [rename_pkg::preg_w-1:0]   out_rs1_preg,
    output logic                            out_rs1_ready,
    output logic [rename_pkg::preg_w-1:0]   out_rs2_preg,
    output logic                            out_rs2_ready,
    output logic [rename_pkg::preg_w-1:0]   out_rd_preg
);

    // Queue head
    logic        q_empty;
    logic        q_pop;
    logic [31:0] q_inst;
    logic [31:0] q_pc;

    // Free list
    logic                          fl_empty;
    logic                          fl_pop;
    logic [rename_pkg::preg_w-1:0] fl_preg;

    // Map lookup and update
    logic [rv32i_pkg::areg_w-1:0]  rs1_areg;
    logic [rv32i_pkg::areg_w-1:0]  rs2_areg;
    logic [rename_pkg::preg_w-1:0] rs1_preg;
    logic [rename_pkg::preg_w-1:0] rs2_preg;
    logic                          rs1_busy;
    logic                          rs2_busy;
    logic                          ren_valid;
    logic [rv32i_pkg::areg_w-1:0]  ren_areg;
    logic [rename_pkg::preg_w-1:0] ren_preg;

    // Dispatched entry
    logic                            credit_avail;
    logic                            disp_valid;
    logic [31:0]                     disp_inst;
    logic [31:0]                     disp_pc;
    logic [rename_pkg::rob_id_w-1:0] disp_rob_id;
    logic [rename_pkg::preg_w-1:0]   disp_rs1_preg;
    logic                            disp_rs1_ready;
    logic [rename_pkg::preg_w-1:0]   disp_rs2_preg;
    logic                            disp_rs2_ready;
    logic [rename_pkg::preg_w-1:0]   disp_rd_preg;

    inst_queue inst_queue_inst (
        .clk, .rst, .in_valid, .in_inst, .in_pc, .q_pop,
        .q_empty, .q_inst, .q_pc, .in_credit
    );

    free_list free_list_inst (
        .clk, .rst, .fl_pop, .retire_valid, .retire_preg,
        .fl_empty, .fl_preg
    );

    rename_table rename_table_inst (
        .clk, .rst, .rs1_areg, .rs2_areg, .ren_valid, .ren_areg, .ren_preg,
        .wb_valid, .wb_preg, .rs1_preg, .rs1_busy, .rs2_preg, .rs2_busy
    );

    dispatcher dispatcher_inst (
        .clk, .rst, .q_empty, .q_inst, .q_pc, .fl_empty, .fl_preg,
        .rs1_preg, .rs1_busy, .rs2_preg, .rs2_busy, .credit_avail, .retire_valid,
        .q_pop, .fl_pop, .rs1_areg, .rs2_areg, .ren_valid, .ren_areg, .ren_preg,
        .disp_valid, .disp_inst, .disp_pc, .disp_rob_id,
        .disp_rs1_preg, .disp_rs1_ready, .disp_rs2_preg, .disp_rs2_ready, .disp_rd_preg
    );

    dispatch_credit_out dispatch_credit_out_inst (
        .clk, .rst, .disp_valid, .disp_inst, .disp_pc, .disp_rob_id,
        .disp_rs1_preg, .disp_rs1_ready, .disp_rs2_preg, .disp_rs2_ready, .disp_rd_preg,
        .out_credit, .credit_avail, .out_valid, .out_inst, .out_pc, .out_rob_id,
        .out_rs1_preg, .out_rs1_ready, .out_rs2_preg, .out_rs2_ready, .out_rd_preg
    );

endmodule

//--- tests/rename_dispatch_assert.sv
// Port-level checks only, and the credit count lags the internal counter by one cycle
`timescale 1ns/1ps

module rename_dispatch_assert (
    input logic                          clk,
    input logic                          rst,
    input logic                          in_credit,
    input logic                          out_valid,
    input logic                          out_credit,
    input logic [31:0]                   out_inst,
    input logic                          out_rs1_ready,
    input logic [rename_pkg::preg_w-1:0] out_rd_preg
);

    logic [6:0] opcode;
    logic       writes_rd;
    int         outstanding;

    assign opcode = out_inst[6:0];
    // Opcodes that have an rd field
    assign writes_rd = opcode inside {rv32i_pkg::op_lui, rv32i_pkg::op_auipc,
        rv32i_pkg::op_jal, rv32i_pkg::op_jalr, rv32i_pkg::op_load,
        rv32i_pkg::op_imm, rv32i_pkg::op_reg};

    // Entries shown to the reservation station minus credits it gave back
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(out_valid) - int'(out_credit);
        end
    end

    rd_preg_only_for_rd: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_rd_preg != '0 |->
        out_inst[rv32i_pkg::rd_lsb +: rv32i_pkg::areg_w] != '0 && writes_rd)
        else $error("rd preg given to an instruction without a real destination");

    rs1_x0_ready: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_inst[rv32i_pkg::rs1_lsb +: rv32i_pkg::areg_w] == '0 |-> out_rs1_ready)
        else $error("rs1 of x0 not reported ready");

    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        outstanding <= rename_pkg::rs_credits)
        else $error("more entries outstanding than reservation station credits");

    no_credit_in_reset: assert property (@(posedge clk) rst |=> !in_credit)
        else $error("in_credit high during reset");

endmodule

bind rename_dispatch_top rename_dispatch_assert rename_dispatch_assert_inst (.*);

//--- tests/rename_dispatch_tb.sv
// Writeback is only driven while the pipeline is drained, so readiness is modeled per drained phase
`timescale 1ns/1ps

module rename_dispatch_tb;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        out_credit;
    logic        wb_valid;
    logic [5:0]  wb_preg;
    logic        retire_valid;
    logic [5:0]  retire_preg;
    logic        in_credit;
    logic        out_valid;
    logic [31:0] out_inst;
    logic [31:0] out_pc;
    logic [2:0]  out_rob_id;
    logic [5:0]  out_rs1_preg;
    logic        out_rs1_ready;
    logic [5:0]  out_rs2_preg;
    logic        out_rs2_ready;
    logic [5:0]  out_rd_preg;

    // Reference model state
    logic [5:0]  ref_map [32];
    logic        ref_busy [64];
    logic [5:0]  free_q [$];
    logic [31:0] sent_inst [$];
    logic [31:0] sent_pc [$];
    logic [5:0]  retire_q [$];
    logic [31:0] lfsr;
    logic [31:0] next_pc;
    int fetch_cred;
    int out_count;
    int rd_used;
    int disp_index;
    int in_credit_count;
    int accepted;
    int rs_pending;
    int rs_delay;
    int auto_left;
    bit rs_hold;
    int errors;
    int checks;
    int tests;
    string test_name;

    rename_dispatch_top rename_dispatch_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(input int k);
        int v;
        logic b;
        v = 0;
        for (int i = 0; i < k; i++) begin
            b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], b};
            v = (v << 1) | int'(b);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_reg(input logic [4:0] rd, rs1, rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, rv32i_pkg::op_reg};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [4:0] rd, rs1);
        return {12'h001, rs1, 3'b000, rd, rv32i_pkg::op_imm};
    endfunction

    task automatic check_value(input string field, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, field, exp, act);
            errors++;
        end
    endtask

    task automatic timeout(input string msg);
        $display("Timeout in test %s: %s", test_name, msg);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Expected entry from the ISA operand rules and the reference map
    task automatic check_entry();
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  use_bits;
        logic [5:0]  e1;
        logic [5:0]  e2;
        logic [5:0]  ed;
        out_count++;
        if (sent_inst.size() == 0) begin
            $display("Test %s saw an output entry that was never sent", test_name);
            errors++;
            return;
        end
        inst = sent_inst.pop_front();
        rd   = inst[11:7];
        rs1  = inst[19:15];
        rs2  = inst[24:20];
        case (inst[6:0])
            rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal: use_bits = 3'b001;
            rv32i_pkg::op_jalr, rv32i_pkg::op_load, rv32i_pkg::op_imm: use_bits = 3'b101;
            rv32i_pkg::op_branch, rv32i_pkg::op_store: use_bits = 3'b110;
            rv32i_pkg::op_reg: use_bits = 3'b111;
            default: use_bits = 3'b000;
        endcase
        e1 = (use_bits[2] && rs1 != 0) ? ref_map[rs1] : 6'd0;
        e2 = (use_bits[1] && rs2 != 0) ? ref_map[rs2] : 6'd0;
        check_value("inst", inst, out_inst);
        check_value("pc", sent_pc.pop_front(), out_pc);
        check_value("rob id", disp_index % rename_pkg::rob_depth, out_rob_id);
        check_value("rs1 preg", e1, out_rs1_preg);
        check_value("rs1 ready", (e1 == 0) ? 1 : !ref_busy[e1], out_rs1_ready);
        check_value("rs2 preg", e2, out_rs2_preg);
        check_value("rs2 ready", (e2 == 0) ? 1 : !ref_busy[e2], out_rs2_ready);
        ed = 6'd0;
        if (use_bits[0] && rd != 0) begin
            if (free_q.size() == 0) begin
                $display("Test %s renamed a register while the free list was empty", test_name);
                errors++;
            end else begin
                ed = free_q.pop_front();
                ref_map[rd] = ed;
                ref_busy[ed] = 1'b1;
            end
        end
        check_value("rd preg", ed, out_rd_preg);
        // Free-list entries the DUT actually handed out
        if (out_rd_preg != '0) begin
            rd_used++;
        end
        disp_index++;
        rs_pending++;
        if (auto_left > 0) begin
            auto_left--;
            retire_q.push_back(6'd0);
        end
    endtask

    // Monitor plus the reservation station and retirement models
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                fetch_cred++;
                in_credit_count++;
            end
            if (out_valid) begin
                check_entry();
            end
            out_credit = 1'b0;
            if (rs_pending > 0 && !rs_hold) begin
                if (rs_delay == 0) begin
                    out_credit = 1'b1;
                    rs_pending--;
                    rs_delay = rand_bits(2);
                end else begin
                    rs_delay--;
                end
            end
            retire_valid = 1'b0;
            if (retire_q.size() > 0) begin
                retire_valid = 1'b1;
                retire_preg = retire_q.pop_front();
                if (retire_preg != 0) free_q.push_back(retire_preg);
            end
        end
    end

    task automatic send(input logic [31:0] inst);
        int t;
        t = 0;
        while (fetch_cred == 0) begin
            @(negedge clk);
            t++;
            if (t > 300) timeout("fetcher never got a credit back");
        end
        in_valid = 1'b1;
        in_inst = inst;
        in_pc = next_pc;
        sent_inst.push_back(inst);
        sent_pc.push_back(next_pc);
        next_pc += 4;
        fetch_cred--;
        accepted++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_outputs(input int n);
        int t;
        t = 0;
        while (out_count < n) begin
            @(negedge clk);
            t++;
            if (t > 500) timeout("expected output entries did not arrive");
        end
    endtask

    // Outputs, credits and retirements all settled
    task automatic drain();
        int t;
        t = 0;
        wait_outputs(out_count + sent_inst.size());
        while (retire_q.size() > 0 || rs_pending > 0) begin
            @(negedge clk);
            t++;
            if (t > 500) timeout("credits or retirements never settled");
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic writeback(input logic [5:0] p);
        wb_valid = 1'b1;
        wb_preg = p;
        ref_busy[p] = 1'b0;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s finished, %0d errors so far", test_name, errors);
    endtask

    initial begin
        int base;
        int cred_base;
        int acc_base;
        int n;
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        out_credit = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        retire_valid = 1'b0;
        retire_preg = '0;
        lfsr = 32'hb07;
        next_pc = 32'h1000;
        fetch_cred = rename_pkg::iq_depth;
        auto_left = 1000000;
        rs_hold = 1'b0;
        for (int i = 0; i < 32; i++) ref_map[i] = i[5:0];
        for (int i = 0; i < 64; i++) ref_busy[i] = 1'b0;
        for (int i = 32; i < 64; i++) free_q.push_back(i[5:0]);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "renaming";
        send(enc_reg(5'd1, 5'd2, 5'd3));
        send(enc_reg(5'd2, 5'd1, 5'd1));
        send(enc_reg(5'd3, 5'd2, 5'd1));
        drain();
        end_test();

        // x1 is busy until its preg is written back
        test_name = "readiness";
        send(enc_reg(5'd5, 5'd1, 5'd0));
        drain();
        writeback(ref_map[1]);
        send(enc_reg(5'd6, 5'd1, 5'd0));
        drain();
        end_test();

        // Only the x7 destination may take a free preg
        test_name = "x0_and_unused";
        n = rd_used;
        send({20'h12345, 5'd0, rv32i_pkg::op_lui});
        send(enc_reg(5'd0, 5'd0, 5'd0));
        send({7'b0, 5'd3, 5'd0, 3'b010, 5'd0, rv32i_pkg::op_store});
        send({7'b0, 5'd0, 5'd2, 3'b000, 5'd4, rv32i_pkg::op_branch});
        send(enc_imm(5'd7, 5'd0));
        drain();
        check_value("free list entries used", 1, rd_used - n);
        end_test();

        // Reservation station returns nothing until released
        test_name = "credit_backpressure";
        rs_hold = 1'b1;
        base = out_count;
        cred_base = in_credit_count;
        acc_base = accepted;
        for (int i = 0; i < 6; i++) send(enc_reg(5'(8 + i), 5'd1, 5'd2));
        wait_outputs(base + rename_pkg::rs_credits);
        repeat (20) @(negedge clk);
        check_value("entries without credit", rename_pkg::rs_credits, out_count - base);
        rs_hold = 1'b0;
        drain();
        check_value("entries after credit", 6, out_count - base);
        check_value("in_credit pulses", accepted - acc_base, in_credit_count - cred_base);
        end_test();

        test_name = "rob_limit";
        auto_left = 0;
        base = out_count;
        for (int i = 0; i < 10; i++) send(enc_reg(5'd0, 5'(i), 5'd1));
        wait_outputs(base + rename_pkg::rob_depth);
        repeat (20) @(negedge clk);
        check_value("dispatches without retire", rename_pkg::rob_depth, out_count - base);
        retire_q.push_back(6'd0);
        retire_q.push_back(6'd0);
        wait_outputs(base + 10);
        for (int i = 0; i < rename_pkg::rob_depth; i++) retire_q.push_back(6'd0);
        drain();
        end_test();

        // Last two renames stay in flight so returns match real retirements
        test_name = "free_list_exhaustion";
        n = free_q.size();
        auto_left = n - 2;
        base = out_count;
        for (int i = 0; i < n; i++) send(enc_reg(5'd9, 5'd9, 5'd0));
        wait_outputs(base + n);
        send(enc_reg(5'd10, 5'd0, 5'd0));
        send(enc_reg(5'd11, 5'd10, 5'd0));
        repeat (20) @(negedge clk);
        check_value("dispatches with empty free list", n, out_count - base);
        retire_q.push_back(6'd40);
        wait_outputs(base + n + 1);
        retire_q.push_back(6'd41);
        wait_outputs(base + n + 2);
        for (int i = 0; i < 2; i++) retire_q.push_back(6'd0);
        drain();
        end_test();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/rv32i_pkg.sv
source/rename_pkg.sv
source/inst_queue.sv
source/free_list.sv
source/rename_table.sv
source/dispatcher.sv
source/dispatch_credit_out.sv
source/rename_dispatch_top.sv
tests/rename_dispatch_assert.sv
tests/rename_dispatch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_dispatch_tb -f verilog.f -o rename_dispatch_sim
./obj_dir/rename_dispatch_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "RESULT: PASS" sim.log
